// File: calc_defines.svh
// Keypad calculator shared constants
// Widths, scan and refresh dividers, and operator key codes
`ifndef CALC_DEFINES_SVH
`define CALC_DEFINES_SVH

`define KEY_W        4       // Key code width
`define ROW_N        4       // Keypad rows, also columns
`define VALUE_W      14      // Holds 99 * 99 = 9801
`define OPND_W       7       // Holds 99
`define BCD_DIGITS   4

// Clock dividers, kept small for simulation
`define SCAN_DIV     8       // Cycles per row step
`define REFRESH_DIV  4       // Cycles per display digit step

// Operator keys, digit keys carry their own value
`define KEY_ADD      4'hA
`define KEY_MUL      4'hB
`define KEY_EQUAL    4'hC
`define KEY_CLEAR    4'hD

`endif

// File: calc_pkg.sv
// Keypad calculator types
// Key codes, binary values, operands, BCD words and the
// double-dabble shift word with its two views
`include "calc_defines.svh"

package calc_pkg;

    typedef logic [`KEY_W-1:0]   key_t;
    typedef logic [`VALUE_W-1:0] value_t;
    typedef logic [`OPND_W-1:0]  opnd_t;

    // Digit 0 is the least significant
    typedef logic [`BCD_DIGITS-1:0][3:0] bcd_word_t;

    // Shift word, seen whole or as BCD digits above the binary remainder
    typedef union packed {
        logic [`BCD_DIGITS*4+`VALUE_W-1:0] raw;
        struct packed {
            bcd_word_t bcd;
            value_t    bin;
        } split;
    } bcd_shift_u;

endpackage

// File: keypad_scanner.sv
// Keypad scanner
// Walks a one-hot row across the 4x4 matrix and samples the columns
// through a two-flop synchronizer. One key strobe per press, issued at
// the end of the first scan round that sees a closed key after an
// empty round.
`timescale 1ns/1ps
`include "calc_defines.svh"

module keypad_scanner (
    input  logic                clk,
    input  logic                rst,
    input  logic [3:0]          col,
    output logic [3:0]          row,
    output calc_pkg::key_t      key,
    output logic                key_strobe
);
    import calc_pkg::*;

    logic [$clog2(`SCAN_DIV)-1:0] div_cnt;
    logic [3:0] col_meta;
    logic [3:0] col_sync;
    logic [1:0] row_idx;
    logic [1:0] col_idx;
    logic       row_end;
    logic       round_end;
    logic       col_hit;
    logic       seen;       // Closed key found earlier in this round
    logic       prev_seen;  // Previous round had a closed key
    key_t       first_key;

    // Key map, row by row
    function automatic key_t key_map(input logic [1:0] r, input logic [1:0] c);
        case ({r, c})
            4'h0: key_map = 4'h1;
            4'h1: key_map = 4'h2;
            4'h2: key_map = 4'h3;
            4'h3: key_map = `KEY_ADD;
            4'h4: key_map = 4'h4;
            4'h5: key_map = 4'h5;
            4'h6: key_map = 4'h6;
            4'h7: key_map = `KEY_MUL;
            4'h8: key_map = 4'h7;
            4'h9: key_map = 4'h8;
            4'hA: key_map = 4'h9;
            4'hB: key_map = `KEY_EQUAL;
            4'hC: key_map = 4'hE;
            4'hD: key_map = 4'h0;
            4'hE: key_map = 4'hF;
            default: key_map = `KEY_CLEAR;
        endcase
    endfunction

    assign row_end   = (div_cnt == `SCAN_DIV - 1);
    assign round_end = row_end && row[`ROW_N-1];
    assign col_hit   = |col_sync;

    // Lowest set bit wins, so column 0 has priority
    always_comb begin
        row_idx = '0;
        col_idx = '0;
        for (int i = `ROW_N - 1; i >= 0; i--) begin
            if (row[i])      row_idx = 2'(i);
            if (col_sync[i]) col_idx = 2'(i);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt    <= '0;
            row        <= 4'b0001;
            col_meta   <= '0;
            col_sync   <= '0;
            seen       <= 1'b0;
            prev_seen  <= 1'b0;
            key_strobe <= 1'b0;
        end else begin
            col_meta   <= col;
            col_sync   <= col_meta;
            key_strobe <= 1'b0;
            div_cnt    <= div_cnt + 1'b1;
            if (row_end) begin
                div_cnt <= '0;
                row     <= {row[`ROW_N-2:0], row[`ROW_N-1]};  // Ring step
                if (round_end) begin
                    key_strobe <= (seen || col_hit) && !prev_seen;
                    prev_seen  <= seen || col_hit;
                    seen       <= 1'b0;
                end else if (col_hit) begin
                    seen <= 1'b1;
                end
            end
        end
    end

    // Key code capture, first hit of the round
    always_ff @(posedge clk) begin
        if (row_end && col_hit && !seen)
            first_key <= key_map(row_idx, col_idx);
        if (round_end)
            key <= seen ? first_key : key_map(row_idx, col_idx);
    end

endmodule

// File: calc_sequencer.sv
// Calculator entry sequencer
// Collects two-digit operands tens first, holds the operator, launches
// the arithmetic on C and sends every value to show to the BCD converter.
// D clears from any state.
`timescale 1ns/1ps
`include "calc_defines.svh"

module calc_sequencer (
    input  logic                clk,
    input  logic                rst,
    input  calc_pkg::key_t      key,
    input  logic                key_strobe,
    output calc_pkg::opnd_t     opnd_a,
    output calc_pkg::opnd_t     opnd_b,
    output logic                is_mul,
    output logic                calc_start,
    input  calc_pkg::value_t    calc_result,
    input  logic                calc_done,
    output calc_pkg::value_t    show_value,
    output logic                show_strobe
);
    import calc_pkg::*;

    localparam logic [2:0] tens_a  = 3'd0;
    localparam logic [2:0] units_a = 3'd1;
    localparam logic [2:0] oper    = 3'd2;
    localparam logic [2:0] tens_b  = 3'd3;
    localparam logic [2:0] units_b = 3'd4;
    localparam logic [2:0] ready   = 3'd5;
    localparam logic [2:0] busy    = 3'd6;
    localparam logic [2:0] shown   = 3'd7;

    logic [2:0] state;
    key_t       tens;
    opnd_t      opnd_new;
    value_t     echo_value;
    logic       echo_strobe;
    logic       is_digit;
    logic       is_clear;
    logic       take_tens;
    logic       take_units;
    logic       take_oper;
    logic       take_equal;

    // Key decode against the current state
    assign is_digit   = key_strobe && (key <= key_t'(9));
    assign is_clear   = key_strobe && (key == `KEY_CLEAR);
    assign take_tens  = is_digit && (state == tens_a || state == tens_b || state == shown);
    assign take_units = is_digit && (state == units_a || state == units_b);
    assign take_oper  = key_strobe && state == oper && (key == `KEY_ADD || key == `KEY_MUL);
    assign take_equal = key_strobe && state == ready && key == `KEY_EQUAL;
    assign opnd_new   = opnd_t'(tens) * opnd_t'(10) + opnd_t'(key);  // Tens x 10 + units

    // Result goes straight through so the display follows done closely
    assign show_value  = (state == busy) ? calc_result : echo_value;
    assign show_strobe = echo_strobe || (calc_done && state == busy);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= tens_a;
            calc_start  <= 1'b0;
            echo_strobe <= 1'b0;
        end else begin
            calc_start  <= take_equal;
            echo_strobe <= is_clear || take_tens || take_units;
            if (is_clear) begin
                state <= tens_a;
            end else begin
                case (state)
                    tens_a, shown: if (take_tens)  state <= units_a;
                    units_a:       if (take_units) state <= oper;
                    oper:          if (take_oper)  state <= tens_b;
                    tens_b:        if (take_tens)  state <= units_b;
                    units_b:       if (take_units) state <= ready;
                    ready:         if (take_equal) state <= busy;
                    default:       if (calc_done)  state <= shown;  // busy
                endcase
            end
        end
    end

    // Operands, operator and echoed value
    always_ff @(posedge clk) begin
        if (take_tens) tens <= key;
        if (take_units && state == units_a) opnd_a <= opnd_new;
        if (take_units && state == units_b) opnd_b <= opnd_new;
        if (take_oper) is_mul <= (key == `KEY_MUL);
        if (is_clear)
            echo_value <= '0;
        else if (take_tens)
            echo_value <= value_t'(key);
        else if (take_units)
            echo_value <= value_t'(opnd_new);
    end

endmodule

// File: arith_unit.sv
// Arithmetic unit
// Adds in one cycle. Multiplies by adding the first operand as many
// times as the second, so the product takes opnd_b + 1 cycles.
`timescale 1ns/1ps

module arith_unit (
    input  logic                clk,
    input  logic                rst,
    input  calc_pkg::opnd_t     opnd_a,
    input  calc_pkg::opnd_t     opnd_b,
    input  logic                is_mul,
    input  logic                calc_start,
    output calc_pkg::value_t    calc_result,
    output logic                calc_done
);
    import calc_pkg::*;

    value_t acc;
    value_t mcand;
    value_t acc_next;
    opnd_t  count;      // Additions still to do
    logic   busy;

    assign acc_next = acc + mcand;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy      <= 1'b0;
            calc_done <= 1'b0;
            count     <= '0;
        end else begin
            calc_done <= 1'b0;
            if (calc_start) begin  // Restarts a running product too
                busy      <= is_mul && (opnd_b != '0);
                calc_done <= !is_mul || (opnd_b == '0);
                count     <= opnd_b;
            end else if (busy) begin
                count <= count - 1'b1;
                if (count == opnd_t'(1)) begin
                    busy      <= 1'b0;
                    calc_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (calc_start) begin
            mcand       <= value_t'(opnd_a);
            acc         <= '0;
            calc_result <= is_mul ? '0 : value_t'(opnd_a) + value_t'(opnd_b);
        end else if (busy) begin
            acc <= acc_next;
            if (count == opnd_t'(1)) calc_result <= acc_next;  // Last addition
        end
    end

endmodule

// File: bin_to_bcd.sv
// Binary to BCD converter
// Iterative double dabble with one shift per cycle. The held digits change
// VALUE_W + 1 cycles after a show strobe.
`timescale 1ns/1ps
`include "calc_defines.svh"

module bin_to_bcd (
    input  logic                clk,
    input  logic                rst,
    input  calc_pkg::value_t    show_value,
    input  logic                show_strobe,
    output calc_pkg::bcd_word_t digits
);
    import calc_pkg::*;

    bcd_shift_u sh;
    bcd_shift_u adj;
    bcd_shift_u nxt;
    logic [$clog2(`VALUE_W+1)-1:0] step_cnt;
    logic busy;

    // Add 3 to each digit of 5 or more before the shift
    always_comb begin
        adj = sh;
        for (int d = 0; d < `BCD_DIGITS; d++) begin
            if (sh.split.bcd[d] >= 4'd5) adj.split.bcd[d] = sh.split.bcd[d] + 4'd3;
        end
        nxt.raw = adj.raw << 1;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy     <= 1'b0;
            step_cnt <= '0;
            digits   <= '0;
        end else if (show_strobe) begin
            busy     <= 1'b1;
            step_cnt <= '0;
        end else if (busy) begin
            step_cnt <= step_cnt + 1'b1;
            if (step_cnt == `VALUE_W - 1) begin  // Last bit shifted in
                busy   <= 1'b0;
                digits <= nxt.split.bcd;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (show_strobe) begin
            sh.split.bcd <= '0;
            sh.split.bin <= show_value;
        end else if (busy) begin
            sh <= nxt;
        end
    end

endmodule

// File: seven_seg_mux.sv
// Seven-segment display multiplexer
// Steps through the four digits at the refresh rate, pulls one anode
// low and decodes that digit to active-low segments
`timescale 1ns/1ps
`include "calc_defines.svh"

module seven_seg_mux (
    input  logic                clk,
    input  logic                rst,
    input  calc_pkg::bcd_word_t digits,
    output logic [6:0]          seg,
    output logic [3:0]          an
);
    import calc_pkg::*;

    logic [$clog2(`REFRESH_DIV)-1:0] ref_cnt;
    logic [$clog2(`BCD_DIGITS)-1:0]  dig_idx;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ref_cnt <= '0;
            dig_idx <= '0;
        end else if (ref_cnt == `REFRESH_DIV - 1) begin
            ref_cnt <= '0;
            dig_idx <= dig_idx + 1'b1;  // Wraps after digit 3
        end else begin
            ref_cnt <= ref_cnt + 1'b1;
        end
    end

    always_comb begin
        an          = '1;
        an[dig_idx] = 1'b0;
    end

    // ******************************************************************
    // Segment table, active low
    // ******************************************************************
    always_comb begin
        case (digits[dig_idx])
            4'h0: seg = 7'b1000000;
            4'h1: seg = 7'b1111001;
            4'h2: seg = 7'b0100100;
            4'h3: seg = 7'b0110000;
            4'h4: seg = 7'b0011001;
            4'h5: seg = 7'b0010010;
            4'h6: seg = 7'b0000010;
            4'h7: seg = 7'b1111000;
            4'h8: seg = 7'b0000000;
            4'h9: seg = 7'b0011000;
            4'hA: seg = 7'b0001000;
            4'hB: seg = 7'b0000011;
            4'hC: seg = 7'b1000110;
            4'hD: seg = 7'b0100001;
            4'hE: seg = 7'b0000110;
            default: seg = 7'b0001110;  // F
        endcase
    end

endmodule

// File: calc_top.sv
// Keypad calculator top level
// Keypad scan, entry sequencing, add or multiply, BCD conversion and
// the multiplexed seven-segment display
`timescale 1ns/1ps

module calc_top (
    input  logic       clk,
    input  logic       rst,
    input  logic [3:0] col,
    output logic [3:0] row,
    output logic [6:0] seg,
    output logic [3:0] an
);
    import calc_pkg::*;

    key_t      key;
    logic      key_strobe;
    opnd_t     opnd_a;
    opnd_t     opnd_b;
    logic      is_mul;
    logic      calc_start;
    value_t    calc_result;
    logic      calc_done;
    value_t    show_value;
    logic      show_strobe;
    bcd_word_t digits;

    // ******************************************************************
    // Input side
    // ******************************************************************
    keypad_scanner u_scanner (
        .clk        (clk),
        .rst        (rst),
        .col        (col),
        .row        (row),
        .key        (key),
        .key_strobe (key_strobe)
    );

    calc_sequencer u_sequencer (
        .clk         (clk),
        .rst         (rst),
        .key         (key),
        .key_strobe  (key_strobe),
        .opnd_a      (opnd_a),
        .opnd_b      (opnd_b),
        .is_mul      (is_mul),
        .calc_start  (calc_start),
        .calc_result (calc_result),
        .calc_done   (calc_done),
        .show_value  (show_value),
        .show_strobe (show_strobe)
    );

    arith_unit u_arith (
        .clk         (clk),
        .rst         (rst),
        .opnd_a      (opnd_a),
        .opnd_b      (opnd_b),
        .is_mul      (is_mul),
        .calc_start  (calc_start),
        .calc_result (calc_result),
        .calc_done   (calc_done)
    );

    // ******************************************************************
    // Display side
    // ******************************************************************
    bin_to_bcd u_bcd (
        .clk         (clk),
        .rst         (rst),
        .show_value  (show_value),
        .show_strobe (show_strobe),
        .digits      (digits)
    );

    seven_seg_mux u_display (
        .clk    (clk),
        .rst    (rst),
        .digits (digits),
        .seg    (seg),
        .an     (an)
    );

endmodule

// File: calc_properties.sv
// Keypad calculator properties
// One low anode at a time, one-hot row scan, and no done strobe
// from the arithmetic unit before a start
`timescale 1ns/1ps

module calc_properties (
    input logic       clk,
    input logic       rst,
    input logic [3:0] an,
    input logic [3:0] row,
    input logic       calc_start,
    input logic       calc_done
);

    logic started;          // A start has been seen since reset
    int   error_count = 0;  // Assertion failures so far

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            started <= 1'b0;
        else if (calc_start)
            started <= 1'b1;
    end

    an_one_low: assert property (@(posedge clk) disable iff (rst) $onehot(~an))
        else begin
            $error("an does not have exactly one low bit");
            error_count++;
        end

    row_one_hot: assert property (@(posedge clk) disable iff (rst) $onehot(row))
        else begin
            $error("row is not one-hot");
            error_count++;
        end

    done_after_start: assert property (@(posedge clk) disable iff (rst) calc_done |-> started)
        else begin
            $error("calc_done fired with no calc_start before it");
            error_count++;
        end

endmodule

bind calc_top calc_properties u_props (
    .clk        (clk),
    .rst        (rst),
    .an         (an),
    .row        (row),
    .calc_start (calc_start),
    .calc_done  (calc_done)
);

// File: calc_checker.sv
// Display checker for the keypad calculator
// Watches the anode and segment pins, waits until every digit position
// shows the expected decimal value for a full refresh cycle, and
// checks that the row scan steps in order meanwhile
`timescale 1ns/1ps
`include "calc_defines.svh"

module calc_checker (
    input  logic       clk,
    input  logic [6:0] seg,
    input  logic [3:0] an,
    input  logic [3:0] row,
    input  logic       check_req,
    input  int         test_id,
    input  int         exp_value,
    output logic       check_done,
    output int         pass_count,
    output int         fail_count
);

    localparam int WINDOW      = `BCD_DIGITS * `REFRESH_DIV;  // One refresh cycle
    localparam int CHECK_LIMIT = 400;

    // Active-low segments, g down to a
    function automatic logic [6:0] seg_of(input int d);
        case (d)
            0: seg_of = 7'b1000000;
            1: seg_of = 7'b1111001;
            2: seg_of = 7'b0100100;
            3: seg_of = 7'b0110000;
            4: seg_of = 7'b0011001;
            5: seg_of = 7'b0010010;
            6: seg_of = 7'b0000010;
            7: seg_of = 7'b1111000;
            8: seg_of = 7'b0000000;
            9: seg_of = 7'b0011000;
            default: seg_of = 7'b1111111;
        endcase
    endfunction

    // Position of the single low anode, -1 if none or several
    function automatic int an_index(input logic [3:0] a);
        an_index = -1;
        for (int i = 0; i < 4; i++)
            if (a === 4'(~(4'b0001 << i))) an_index = i;
    endfunction

    // ******************************************************************
    // One check, ends on a settled display or at the limit
    // ******************************************************************
    task automatic run_check();
        logic [6:0] want [`BCD_DIGITS];
        int         v;
        int         idx;
        int         streak;
        int         steps;
        int         cycles;
        logic       done;
        logic       bad_seg;
        logic       bad_an;
        logic       bad_row;
        logic [3:0] prev_row;
        logic [3:0] next_row;
        logic [6:0] got_seg;
        logic [6:0] exp_seg;
        logic [3:0] got_an;
        logic [3:0] got_row;
        logic [3:0] exp_row;

        v = exp_value;
        for (int i = 0; i < `BCD_DIGITS; i++) begin
            want[i] = seg_of(v % 10);
            v = v / 10;
        end
        streak   = 0;
        steps    = 0;
        done     = 1'b0;
        bad_seg  = 1'b0;
        bad_an   = 1'b0;
        bad_row  = 1'b0;
        got_seg  = '0;
        exp_seg  = '0;
        got_an   = '0;
        got_row  = '0;
        exp_row  = '0;
        prev_row = row;

        for (cycles = 0; cycles < CHECK_LIMIT && !done; cycles++) begin
            @(negedge clk);  // Pins settle after the rising edge
            idx = an_index(an);
            if (idx < 0) begin
                streak = 0;
                bad_an = 1'b1;
                got_an = an;
            end else if (seg !== want[idx]) begin
                streak  = 0;
                bad_seg = 1'b1;
                got_seg = seg;
                exp_seg = want[idx];
                got_an  = an;
            end else begin
                streak++;
            end
            next_row = {prev_row[2:0], prev_row[3]};
            if (row !== prev_row) begin
                if (row === next_row) begin
                    steps++;
                end else begin
                    bad_row = 1'b1;
                    got_row = row;
                    exp_row = next_row;
                end
                prev_row = row;
            end
            done = bad_row || (streak >= WINDOW && steps >= `ROW_N);
        end

        if (!bad_row && streak >= WINDOW && steps >= `ROW_N) begin
            pass_count++;
            $display("PASS test %0d: display shows %04d", test_id, exp_value);
        end else begin
            fail_count++;
            if (bad_row)
                $display("FAIL test %0d: row = 0x%h, expected 0x%h", test_id, got_row, exp_row);
            else if (bad_seg)
                $display("FAIL test %0d: seg = 0x%h, expected 0x%h at an = 0x%h",
                         test_id, got_seg, exp_seg, got_an);
            else if (bad_an)
                $display("FAIL test %0d: an = 0x%h, expected one low bit", test_id, got_an);
            else
                $display("FAIL test %0d: display did not settle before the time limit",
                         test_id);
        end
    endtask

    initial begin
        check_done = 1'b0;
        pass_count = 0;
        fail_count = 0;
        forever begin
            @(posedge clk);
            if (check_req) begin
                run_check();
                @(posedge clk);
                check_done = 1'b1;
                @(posedge clk);
                check_done = 1'b0;
            end
        end
    end

endmodule

// File: tb_calc.sv
// Keypad calculator testbench
// Models the key matrix, applies a table of key sequences with their
// expected display values and hands each value to the display checker
`timescale 1ns/1ps
`include "calc_defines.svh"

module tb_calc;

    localparam int ROUND        = `ROW_N * `SCAN_DIV;  // Cycles per scan round
    localparam int FIXED_N      = 10;
    localparam int RAND_N       = 4;
    localparam int DONE_TIMEOUT = 1000;

    logic       clk;
    logic       rst;
    logic [3:0] col;
    logic [3:0] row;
    logic [6:0] seg;
    logic [3:0] an;
    logic       check_req;
    int         test_id;
    int         exp_value;
    logic       check_done;
    int         pass_count;
    int         fail_count;
    logic       key_down;
    int         key_row;
    int         key_col;
    logic       wait_timeout;
    int         seed;
    int         a;
    int         b;
    string      seqs [$];
    int         expects [$];

    // Keys in row order with column 0 first within a row
    string key_layout = "123A456B789CE0FD";

    // ******************************************************************
    // Stimulus table
    // ******************************************************************
    string fixed_keys [FIXED_N] = '{
        "", "12", "D12A34C", "D99A99C", "D99B99C",
        "D45D", "D3EFAC", "D07B00C", "D12AEFAC", "D12A34C5"
    };
    int fixed_value [FIXED_N] = '{0, 12, 46, 198, 9801, 0, 3, 0, 12, 5};

    calc_top dut (
        .clk (clk),
        .rst (rst),
        .col (col),
        .row (row),
        .seg (seg),
        .an  (an)
    );

    calc_checker u_checker (
        .clk        (clk),
        .seg        (seg),
        .an         (an),
        .row        (row),
        .check_req  (check_req),
        .test_id    (test_id),
        .exp_value  (exp_value),
        .check_done (check_done),
        .pass_count (pass_count),
        .fail_count (fail_count)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Pressed column follows its row
    always @(negedge clk) begin
        if (key_down && row[key_row])
            col <= 4'b0001 << key_col;
        else
            col <= 4'b0000;
    end

    function automatic int key_position(input byte ch);
        key_position = 0;
        for (int i = 0; i < 16; i++)
            if (key_layout[i] == ch) key_position = i;
    endfunction

    // Hold for three scan rounds and release for three
    task automatic press_key(input byte ch);
        int pos;
        pos = key_position(ch);
        @(posedge clk);
        key_row  = pos / 4;
        key_col  = pos % 4;
        key_down = 1'b1;
        repeat (3 * ROUND) @(posedge clk);
        key_down = 1'b0;
        repeat (3 * ROUND) @(posedge clk);
    endtask

    task automatic apply_keys(input string s);
        for (int i = 0; i < s.len(); i++)
            press_key(s[i]);
    endtask

    task automatic request_check(input int id, input int value);
        int t;
        @(negedge clk);
        test_id   = id;
        exp_value = value;
        check_req = 1'b1;
        @(negedge clk);
        check_req = 1'b0;
        for (t = 0; t < DONE_TIMEOUT && !check_done; t++)
            @(negedge clk);
        if (!check_done) begin
            $display("Test %0d: the checker gave no result within %0d cycles", id, DONE_TIMEOUT);
            wait_timeout = 1'b1;
        end
    endtask

    initial begin
        rst          = 1'b1;
        col          = 4'b0000;
        check_req    = 1'b0;
        test_id      = 0;
        exp_value    = 0;
        key_down     = 1'b0;
        key_row      = 0;
        key_col      = 0;
        wait_timeout = 1'b0;
        seed         = 83;

        for (int i = 0; i < FIXED_N; i++) begin
            seqs.push_back(fixed_keys[i]);
            expects.push_back(fixed_value[i]);
        end
        for (int i = 0; i < RAND_N; i++) begin  // Random products
            a = {$random(seed)} % 100;
            b = {$random(seed)} % 100;
            seqs.push_back($sformatf("D%02dB%02dC", a, b));
            expects.push_back(a * b);
        end

        repeat (8) @(negedge clk);
        rst = 1'b0;

        for (int t = 0; t < seqs.size() && !wait_timeout; t++) begin
            apply_keys(seqs[t]);
            request_check(t, expects[t]);
        end

        $display("Tests: %0d passed, %0d failed, %0d assertion errors",
                 pass_count, fail_count, dut.u_props.error_count);
        if (fail_count == 0 && !wait_timeout && dut.u_props.error_count == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: src.f
+incdir+.
calc_pkg.sv
keypad_scanner.sv
calc_sequencer.sv
arith_unit.sv
bin_to_bcd.sv
seven_seg_mux.sv
calc_top.sv
calc_properties.sv
calc_checker.sv
tb_calc.sv

// File: Bender.yml
package:
  name: keypad_calc

export_include_dirs:
  - .

sources:
  - calc_pkg.sv
  - keypad_scanner.sv
  - calc_sequencer.sv
  - arith_unit.sv
  - bin_to_bcd.sv
  - seven_seg_mux.sv
  - calc_top.sv
  - target: test
    files:
      - calc_properties.sv
      - calc_checker.sv
      - tb_calc.sv
